/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mem_stage_pkg.sv
      - design/dcache_ctrl.sv
      - design/dcache_array.sv
      - design/load_store_align.sv
      - design/pwm_timer.sv
      - design/mem_wb_reg.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - bench/mem_stage_sva.sv
      - bench/mem_stage_tb.sv

/* bench/mem_stage_sva.sv */
`timescale 1ns/1ps

module mem_stage_sva (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 mm_req_o,
    input logic                 mm_rd_o,
    input logic                 mm_wr_o,
    input mem_stage_pkg::addr_t mm_addr_o,
    input mem_stage_pkg::line_t mm_wdata_o,
    input logic                 mm_valid_i,
    input logic                 stall_o,
    input logic                 rd_wen_o
);

    // One transfer direction per request
    a_one_dir: assert property (@(posedge clk_i) disable iff (!rst_i)
        mm_req_o |-> !(mm_rd_o && mm_wr_o))
        else $error("mm_rd_o and mm_wr_o asserted together");

    // Request held until the valid pulse
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        (mm_req_o && !mm_valid_i) |=> (mm_req_o && $stable(mm_rd_o) && $stable(mm_wr_o)
                                       && $stable(mm_addr_o) && $stable(mm_wdata_o)))
        else $error("Main-memory request changed before mm_valid_i");

    a_stall_wen: assert property (@(posedge clk_i) disable iff (!rst_i)
        stall_o |=> !rd_wen_o)
        else $error("rd_wen_o high after a stall cycle");

endmodule

bind mem_stage_top mem_stage_sva u_sva (.*);

/* bench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int N_MAX    = 40;
    localparam int MEM_SIZE = 8192;    // Bytes covered by the memory model
    localparam int TIMEOUT  = 200;
    localparam logic [1:0] OP_LD = 2'd0;
    localparam logic [1:0] OP_ST = 2'd1;
    localparam logic [1:0] OP_MM = 2'd2;    // Compare a main-memory word

    logic                     clk_i, rst_i, mem_rd_i, mem_wr_i, rd_wen_i;
    mem_stage_pkg::addr_t     addr_i, mm_addr_o;
    mem_stage_pkg::word_t     wdata_i, rd_data_i, rd_data_o, load_data_o;
    mem_stage_pkg::ls_funct_t funct_i;
    mem_stage_pkg::reg_idx_t  rd_idx_i, rd_idx_o;
    logic                     stall_o, rd_wen_o, load_valid_o, pwm_o;
    logic                     mm_req_o, mm_rd_o, mm_wr_o, mm_ready_i, mm_valid_i;
    mem_stage_pkg::line_t     mm_wdata_o, mm_rdata_i;

    // Stimulus table
    logic [1:0]               op_tab    [N_MAX];
    mem_stage_pkg::ls_funct_t funct_tab [N_MAX];
    mem_stage_pkg::addr_t     addr_tab  [N_MAX];
    mem_stage_pkg::word_t     wdata_tab [N_MAX];
    mem_stage_pkg::word_t     exp_tab   [N_MAX];
    logic                     miss_tab  [N_MAX];
    int                       n_ent;

    logic [7:0]           ref_mem [MEM_SIZE];      // Byte-addressed reference
    logic [15:0]          ref_period, ref_duty;
    mem_stage_pkg::line_t blocks [MEM_SIZE/16];    // Main-memory model
    logic                 mm_busy, mm_is_rd;
    mem_stage_pkg::addr_t mm_blk;
    int                   mm_wait, seed_val, high_cnt, i;

    mem_stage_top dut0 (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [7:0] fill_byte(input mem_stage_pkg::addr_t a);
        mem_stage_pkg::addr_t h;
        h = a * 32'h9E37_79B1;
        return h[31:24] ^ h[7:0];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    function automatic mem_stage_pkg::word_t ref_load(input mem_stage_pkg::ls_funct_t f,
                                                      input mem_stage_pkg::addr_t a);
        logic [31:0] w;
        if (a[30]) return a[2] ? {16'h0, ref_duty} : {16'h0, ref_period};   // PWM registers
        w = {ref_mem[a[12:0]+3], ref_mem[a[12:0]+2], ref_mem[a[12:0]+1], ref_mem[a[12:0]]};
        case (f)
            3'd0:    return {{24{w[7]}}, w[7:0]};
            3'd4:    return {24'h0, w[7:0]};
            3'd1:    return {{16{w[15]}}, w[15:0]};
            3'd5:    return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic ref_store(input mem_stage_pkg::ls_funct_t f, input mem_stage_pkg::addr_t a,
                             input mem_stage_pkg::word_t d);
        if (a[30]) begin
            if (a[2]) ref_duty = d[15:0];
            else      ref_period = d[15:0];
        end else begin
            ref_mem[a[12:0]] = d[7:0];
            if (f != 3'd0) ref_mem[a[12:0]+1] = d[15:8];
            if (f == 3'd2) begin
                ref_mem[a[12:0]+2] = d[23:16];
                ref_mem[a[12:0]+3] = d[31:24];
            end
        end
    endtask

    task automatic add_entry(input logic [1:0] op, input mem_stage_pkg::ls_funct_t f,
                             input mem_stage_pkg::addr_t a, input mem_stage_pkg::word_t d,
                             input logic miss);
        op_tab[n_ent]    = op;
        funct_tab[n_ent] = f;
        addr_tab[n_ent]  = a;
        wdata_tab[n_ent] = d;
        miss_tab[n_ent]  = miss;      // Expected stall in the first cycle
        if (op == OP_ST) ref_store(f, a, d);
        exp_tab[n_ent] = (op == OP_ST) ? 32'h0 : ref_load((op == OP_MM) ? 3'd2 : f, a);
        n_ent++;
    endtask

    task automatic build_table();
        int k;
        add_entry(OP_LD, 3'd2, 32'h100, 0, 1);     // Cold miss
        add_entry(OP_ST, 3'd2, 32'h100, 32'hDEAD_BEEF, 0);
        add_entry(OP_LD, 3'd2, 32'h100, 0, 0);
        add_entry(OP_ST, 3'd2, 32'h214, 32'hCAFE_F00D, 1);     // Store miss
        add_entry(OP_LD, 3'd2, 32'h214, 0, 0);
        add_entry(OP_ST, 3'd0, 32'h320, 32'h81, 1);
        add_entry(OP_ST, 3'd0, 32'h321, 32'h7F, 0);
        add_entry(OP_ST, 3'd1, 32'h322, 32'h8001, 0);
        for (k = 0; k < 4; k++) begin
            add_entry(OP_LD, 3'd0, 32'h320 + k, 0, 0);
            add_entry(OP_LD, 3'd4, 32'h320 + k, 0, 0);
        end
        for (k = 0; k < 4; k += 2) begin
            add_entry(OP_LD, 3'd1, 32'h320 + k, 0, 0);
            add_entry(OP_LD, 3'd5, 32'h320 + k, 0, 0);
        end
        // Index 3 conflict, dirty victims
        add_entry(OP_ST, 3'd2, 32'h330, 32'h1122_3344, 1);
        add_entry(OP_ST, 3'd2, 32'h1330, 32'h5566_7788, 1);
        add_entry(OP_MM, 3'd2, 32'h330, 0, 0);
        add_entry(OP_MM, 3'd2, 32'h33C, 0, 0);
        add_entry(OP_LD, 3'd2, 32'h330, 0, 1);
        add_entry(OP_MM, 3'd2, 32'h1330, 0, 0);
        add_entry(OP_LD, 3'd2, 32'h1330, 0, 1);
        add_entry(OP_ST, 3'd2, 32'h4000_0000, 32'd10, 0);    // PWM period
        add_entry(OP_ST, 3'd2, 32'h4000_0004, 32'd3, 0);     // PWM duty
        add_entry(OP_LD, 3'd2, 32'h4000_0000, 0, 0);
        add_entry(OP_LD, 3'd2, 32'h4000_0004, 0, 0);
    endtask

    task automatic run_entry(input int idx);
        int t;
        mem_stage_pkg::addr_t a;
        a = addr_tab[idx];
        if (op_tab[idx] == OP_MM) begin
            check_value($sformatf("main memory word 0x%08h", a),
                        blocks[a[12:4]][a[3:2]*32 +: 32], exp_tab[idx]);
        end else begin
            @(posedge clk_i);
            mem_rd_i  <= (op_tab[idx] == OP_LD);
            mem_wr_i  <= (op_tab[idx] == OP_ST);
            addr_i    <= a;
            wdata_i   <= wdata_tab[idx];
            funct_i   <= funct_tab[idx];
            rd_wen_i  <= (op_tab[idx] == OP_LD);
            rd_idx_i  <= idx[4:0];
            rd_data_i <= 32'hA500_0000 + idx;
            @(negedge clk_i);
            check_value("stall_o", stall_o, miss_tab[idx]);
            t = 0;
            while (1) begin
                check_value("rd_wen_o", rd_wen_o, 0);    // Nothing leaves while stalled
                check_value("load_valid_o", load_valid_o, 0);
                if (!stall_o) break;
                if (t == TIMEOUT) abort_run("Timeout: stall_o never fell after a cache miss");
                t++;
                @(negedge clk_i);
            end
            @(posedge clk_i);
            mem_rd_i <= 1'b0;
            mem_wr_i <= 1'b0;
            rd_wen_i <= 1'b0;
            @(negedge clk_i);
            check_value("rd_wen_o", rd_wen_o, op_tab[idx] == OP_LD);
            check_value("rd_idx_o", rd_idx_o, idx[4:0]);
            check_value("rd_data_o", rd_data_o, 32'hA500_0000 + idx);
            check_value("load_valid_o", load_valid_o, op_tab[idx] == OP_LD);
            if (op_tab[idx] == OP_LD) check_value("load_data_o", load_data_o, exp_tab[idx]);
        end
    endtask

    // Main memory, random latency and ready drops
    always @(posedge clk_i) begin
        mm_valid_i <= 1'b0;
        mm_ready_i <= ($urandom_range(3, 0) != 0);
        if (!rst_i) begin
            mm_busy <= 1'b0;
        end else if (mm_busy) begin
            if (mm_wait == 0) begin
                mm_valid_i <= 1'b1;
                mm_busy    <= 1'b0;
                if (mm_is_rd) mm_rdata_i <= blocks[mm_blk[12:4]];
            end else begin
                mm_wait <= mm_wait - 1;
            end
        end else if (mm_req_o && !mm_valid_i) begin
            mm_busy  <= 1'b1;
            mm_is_rd <= mm_rd_o;
            mm_blk   <= mm_addr_o;
            mm_wait  <= $urandom_range(5, 0);    // 1 to 6 cycles until valid
            if (mm_wr_o) blocks[mm_addr_o[12:4]] = mm_wdata_o;
        end
    end

    initial begin
        seed_val   = $urandom(61109);
        clk_i      = 1'b0;
        rst_i      = 1'b0;
        mem_rd_i   = 1'b0;
        mem_wr_i   = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        funct_i    = '0;
        rd_wen_i   = 1'b0;
        rd_idx_i   = '0;
        rd_data_i  = '0;
        mm_ready_i = 1'b0;
        mm_valid_i = 1'b0;
        mm_rdata_i = '0;
        ref_period = '0;
        ref_duty   = '0;
        n_ent      = 0;
        for (i = 0; i < MEM_SIZE; i++) begin
            ref_mem[i] = fill_byte(i);
            blocks[i/16][(i%16)*8 +: 8] = fill_byte(i);
        end
        build_table();
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        check_value("stall_o", stall_o, 0);
        check_value("mm_req_o", mm_req_o, 0);
        check_value("mm_rd_o", mm_rd_o, 0);
        check_value("mm_wr_o", mm_wr_o, 0);
        check_value("rd_wen_o", rd_wen_o, 0);
        check_value("load_valid_o", load_valid_o, 0);
        check_value("pwm_o", pwm_o, 0);
        for (i = 0; i < n_ent; i++) run_entry(i);
        // High time of pwm_o over two periods
        repeat (4) @(negedge clk_i);
        high_cnt = 0;
        repeat (2 * ref_period) begin
            @(negedge clk_i);
            if (pwm_o) high_cnt++;
        end
        check_value("pwm_o high cycles", high_cnt, 2 * ref_duty);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/mem_stage_pkg.sv
design/dcache_ctrl.sv
design/dcache_array.sv
design/load_store_align.sv
design/pwm_timer.sv
design/mem_wb_reg.sv
design/mem_stage_top.sv
bench/mem_stage_sva.sv
bench/mem_stage_tb.sv

/* design/dcache_array.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module dcache_array (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  mem_stage_pkg::index_t index_i,
    input  mem_stage_pkg::tag_t   tag_i,
    input  logic [1:0]            word_sel_i,
    input  logic                  store_i,
    input  logic [3:0]            byte_en_i,
    input  mem_stage_pkg::word_t  store_word_i,
    input  logic                  line_wr_i,
    input  logic                  line_clean_i,
    input  mem_stage_pkg::line_t  line_i,
    output logic                  hit_o,
    output logic                  victim_dirty_o,
    output mem_stage_pkg::tag_t   victim_tag_o,
    output mem_stage_pkg::line_t  victim_line_o,
    output mem_stage_pkg::word_t  read_word_o
);

    logic [`MS_DCACHE_LINES-1:0] valid_q;
    logic [`MS_DCACHE_LINES-1:0] dirty_q;
    mem_stage_pkg::tag_t         tag_q  [`MS_DCACHE_LINES];
    mem_stage_pkg::line_t        data_q [`MS_DCACHE_LINES];

    assign hit_o          = valid_q[index_i] && (tag_q[index_i] == tag_i);
    assign victim_dirty_o = valid_q[index_i] && dirty_q[index_i];
    assign victim_tag_o   = tag_q[index_i];
    assign victim_line_o  = data_q[index_i];
    assign read_word_o    = data_q[index_i][word_sel_i*32 +: 32];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (line_wr_i) valid_q[index_i] <= 1'b1;
            if (line_clean_i) begin
                dirty_q[index_i] <= 1'b0;
            end else if (store_i && hit_o) begin
                dirty_q[index_i] <= 1'b1;   // Write-back policy
            end
        end
    end

    // Line storage
    always_ff @(posedge clk_i) begin
        if (line_wr_i) begin
            tag_q[index_i]  <= tag_i;
            data_q[index_i] <= line_i;
        end else if (store_i && hit_o) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en_i[b]) data_q[index_i][word_sel_i*32 + b*8 +: 8] <= store_word_i[b*8 +: 8];
            end
        end
    end

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 access_i,       // Load or store to the cached region
    input  logic                 hit_i,
    input  logic                 victim_dirty_i,
    input  mem_stage_pkg::tag_t  victim_tag_i,
    input  mem_stage_pkg::addr_t addr_i,
    input  logic                 mm_ready_i,
    input  logic                 mm_valid_i,
    output logic                 mm_req_o,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o,
    output mem_stage_pkg::addr_t mm_addr_o,
    output logic                 line_wr_o,
    output logic                 line_clean_o,
    output logic                 stall_o
);

    mem_stage_pkg::dc_state_t state_q, state_d;
    mem_stage_pkg::index_t    index;
    logic                     busy;
    logic                     req_q;      // Request already issued, waiting for valid
    logic                     xfer_done;

    assign index = addr_i[4 +: mem_stage_pkg::INDEX_W];

    assign busy = (state_q == mem_stage_pkg::WRITEBACK) || (state_q == mem_stage_pkg::REFILL);

    // First request cycle needs ready, after that hold until valid
    assign mm_req_o  = busy && (req_q || mm_ready_i);
    assign mm_rd_o   = mm_req_o && (state_q == mem_stage_pkg::REFILL);
    assign mm_wr_o   = mm_req_o && (state_q == mem_stage_pkg::WRITEBACK);
    assign xfer_done = mm_req_o && mm_valid_i;

    // Block-aligned address of the victim or of the missing line
    assign mm_addr_o = (state_q == mem_stage_pkg::WRITEBACK) ?
                       {victim_tag_i, index, 4'b0000} : {addr_i[31:4], 4'b0000};

    assign stall_o = busy || ((state_q == mem_stage_pkg::IDLE) && access_i && !hit_i);

    assign line_wr_o    = xfer_done && (state_q == mem_stage_pkg::REFILL);
    assign line_clean_o = xfer_done;    // Victim written back or fresh line

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_stage_pkg::IDLE: begin
                if (access_i && !hit_i) begin
                    state_d = victim_dirty_i ? mem_stage_pkg::WRITEBACK : mem_stage_pkg::REFILL;
                end
            end
            mem_stage_pkg::WRITEBACK: begin
                if (xfer_done) state_d = mem_stage_pkg::REFILL;
            end
            mem_stage_pkg::REFILL: begin
                if (xfer_done) state_d = mem_stage_pkg::DONE;
            end
            default: state_d = mem_stage_pkg::IDLE;   // DONE, the hit completes here
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= mem_stage_pkg::IDLE;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (xfer_done) begin
                req_q <= 1'b0;
            end else if (mm_req_o) begin
                req_q <= 1'b1;
            end
        end
    end

endmodule

/* design/load_store_align.sv */
`timescale 1ns/1ps

module load_store_align (
    input  mem_stage_pkg::ls_funct_t funct_i,
    input  logic [1:0]               byte_off_i,
    input  mem_stage_pkg::word_t     wdata_i,
    input  mem_stage_pkg::word_t     rword_i,
    output logic [3:0]               byte_en_o,
    output mem_stage_pkg::word_t     store_word_o,
    output mem_stage_pkg::word_t     load_word_o
);

    mem_stage_pkg::word_t shifted;

    // Store side, data replicated into every lane
    always_comb begin
        case (funct_i)
            mem_stage_pkg::LS_B: begin
                store_word_o = {4{wdata_i[7:0]}};
                byte_en_o    = 4'b0001 << byte_off_i;
            end
            mem_stage_pkg::LS_H: begin
                store_word_o = {2{wdata_i[15:0]}};
                byte_en_o    = 4'b0011 << {byte_off_i[1], 1'b0};
            end
            default: begin  // SW
                store_word_o = wdata_i;
                byte_en_o    = 4'b1111;
            end
        endcase
    end

    assign shifted = rword_i >> {byte_off_i, 3'b000};

    // Load side
    always_comb begin
        case (funct_i)
            mem_stage_pkg::LS_B:  load_word_o = {{24{shifted[7]}}, shifted[7:0]};
            mem_stage_pkg::LS_BU: load_word_o = {24'h0, shifted[7:0]};
            mem_stage_pkg::LS_H:  load_word_o = {{16{shifted[15]}}, shifted[15:0]};
            mem_stage_pkg::LS_HU: load_word_o = {16'h0, shifted[15:0]};
            mem_stage_pkg::LS_W:  load_word_o = rword_i;
            default:              load_word_o = rword_i;   // Reserved codes
        endcase
    end

endmodule

/* design/mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Direct-mapped data cache size, in lines of 16 bytes
`define MS_DCACHE_LINES \
    16

// Counter width of the memory-mapped PWM timer
`define MS_PWM_WIDTH \
    16

`endif

/* design/mem_stage_pkg.sv */
package mem_stage_pkg;

`include "mem_stage_config.svh"

    // Address split: tag | index | 4-bit line offset
    localparam int INDEX_W = $clog2(`MS_DCACHE_LINES);
    localparam int TAG_W   = 32 - INDEX_W - 4;

    typedef logic [31:0]        word_t;
    typedef logic [31:0]        addr_t;
    typedef logic [127:0]       line_t;      // Also the main-memory block
    typedef logic [4:0]         reg_idx_t;
    typedef logic [2:0]         ls_funct_t;  // RV32I load/store funct3
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // funct3 codes
    localparam ls_funct_t LS_B  = 3'd0;
    localparam ls_funct_t LS_H  = 3'd1;
    localparam ls_funct_t LS_W  = 3'd2;
    localparam ls_funct_t LS_BU = 3'd4;
    localparam ls_funct_t LS_HU = 3'd5;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        DONE
    } dc_state_t;

endpackage

/* design/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     mem_rd_i,
    input  logic                     mem_wr_i,
    input  mem_stage_pkg::addr_t     addr_i,
    input  mem_stage_pkg::word_t     wdata_i,
    input  mem_stage_pkg::ls_funct_t funct_i,
    input  logic                     rd_wen_i,
    input  mem_stage_pkg::reg_idx_t  rd_idx_i,
    input  mem_stage_pkg::word_t     rd_data_i,
    output logic                     stall_o,
    output logic                     rd_wen_o,
    output mem_stage_pkg::reg_idx_t  rd_idx_o,
    output mem_stage_pkg::word_t     rd_data_o,
    output logic                     load_valid_o,
    output mem_stage_pkg::word_t     load_data_o,
    output logic                     mm_req_o,
    output logic                     mm_rd_o,
    output logic                     mm_wr_o,
    output mem_stage_pkg::addr_t     mm_addr_o,
    output mem_stage_pkg::line_t     mm_wdata_o,
    input  logic                     mm_ready_i,
    input  logic                     mm_valid_i,
    input  mem_stage_pkg::line_t     mm_rdata_i,
    output logic                     pwm_o
);

    logic                 cache_sel, io_sel;
    logic                 hit, victim_dirty, line_wr, line_clean;
    mem_stage_pkg::tag_t  victim_tag;
    mem_stage_pkg::word_t cache_word, io_word, rword, store_word, load_word;
    logic [3:0]           byte_en;

    // Address bit 30 splits cache and I/O space
    assign cache_sel = (mem_rd_i || mem_wr_i) && !addr_i[30];
    assign io_sel    = (mem_rd_i || mem_wr_i) && addr_i[30];
    assign rword     = addr_i[30] ? io_word : cache_word;

    dcache_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .access_i(cache_sel), .hit_i(hit),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag), .addr_i(addr_i),
        .mm_ready_i(mm_ready_i), .mm_valid_i(mm_valid_i), .mm_req_o(mm_req_o),
        .mm_rd_o(mm_rd_o), .mm_wr_o(mm_wr_o), .mm_addr_o(mm_addr_o),
        .line_wr_o(line_wr), .line_clean_o(line_clean), .stall_o(stall_o)
    );

    dcache_array u_array (
        .clk_i(clk_i), .rst_i(rst_i),
        .index_i(addr_i[4 +: mem_stage_pkg::INDEX_W]),
        .tag_i(addr_i[31 -: mem_stage_pkg::TAG_W]),
        .word_sel_i(addr_i[3:2]), .store_i(cache_sel && mem_wr_i), .byte_en_i(byte_en),
        .store_word_i(store_word), .line_wr_i(line_wr), .line_clean_i(line_clean),
        .line_i(mm_rdata_i), .hit_o(hit), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag), .victim_line_o(mm_wdata_o), .read_word_o(cache_word)
    );

    load_store_align u_align (
        .funct_i(funct_i), .byte_off_i(addr_i[1:0]), .wdata_i(wdata_i), .rword_i(rword),
        .byte_en_o(byte_en), .store_word_o(store_word), .load_word_o(load_word)
    );

    pwm_timer u_pwm (
        .clk_i(clk_i), .rst_i(rst_i), .sel_i(io_sel), .wr_i(mem_wr_i),
        .reg_sel_i(addr_i[2]),   // Period at +0, duty at +4
        .wdata_i(store_word), .byte_en_i(byte_en), .rdata_o(io_word), .pwm_o(pwm_o)
    );

    mem_wb_reg u_wb (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_o), .rd_wen_i(rd_wen_i),
        .rd_idx_i(rd_idx_i), .rd_data_i(rd_data_i), .load_i(mem_rd_i),
        .load_data_i(load_word), .rd_wen_o(rd_wen_o), .rd_idx_o(rd_idx_o),
        .rd_data_o(rd_data_o), .load_valid_o(load_valid_o), .load_data_o(load_data_o)
    );

endmodule

/* design/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic                    rd_wen_i,
    input  mem_stage_pkg::reg_idx_t rd_idx_i,
    input  mem_stage_pkg::word_t    rd_data_i,
    input  logic                    load_i,
    input  mem_stage_pkg::word_t    load_data_i,
    output logic                    rd_wen_o,
    output mem_stage_pkg::reg_idx_t rd_idx_o,
    output mem_stage_pkg::word_t    rd_data_o,
    output logic                    load_valid_o,
    output mem_stage_pkg::word_t    load_data_o
);

    // Enables drop to 0 while the stage is stalled
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rd_wen_o     <= 1'b0;
            load_valid_o <= 1'b0;
        end else begin
            rd_wen_o     <= rd_wen_i && !stall_i;
            load_valid_o <= load_i && !stall_i;
        end
    end

    // Data fields hold during a stall
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_idx_o    <= rd_idx_i;
            rd_data_o   <= rd_data_i;
            load_data_o <= load_data_i;
        end
    end

endmodule

/* design/pwm_timer.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module pwm_timer (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 sel_i,
    input  logic                 wr_i,
    input  logic                 reg_sel_i,    // 0 period, 1 duty
    input  mem_stage_pkg::word_t wdata_i,
    input  logic [3:0]           byte_en_i,
    output mem_stage_pkg::word_t rdata_o,
    output logic                 pwm_o
);

    logic [`MS_PWM_WIDTH-1:0] period_q;
    logic [`MS_PWM_WIDTH-1:0] duty_q;
    logic [`MS_PWM_WIDTH-1:0] cnt_q;
    mem_stage_pkg::word_t     new_word;

    assign rdata_o = reg_sel_i ? mem_stage_pkg::word_t'(duty_q) : mem_stage_pkg::word_t'(period_q);

    // Byte-lane merge into the selected register
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = byte_en_i[b] ? wdata_i[b*8 +: 8] : rdata_o[b*8 +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            period_q <= '0;
            duty_q   <= '0;
            cnt_q    <= '0;
            pwm_o    <= 1'b0;
        end else begin
            if (sel_i && wr_i) begin
                if (reg_sel_i) duty_q <= new_word[`MS_PWM_WIDTH-1:0];
                else           period_q <= new_word[`MS_PWM_WIDTH-1:0];
            end
            if ((period_q == '0) || (cnt_q >= period_q - 1'b1)) begin
                cnt_q <= '0;    // Wrap, or parked while period is 0
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            pwm_o <= (period_q != '0) && (cnt_q < duty_q);
        end
    end

endmodule
